//--- rtl/fe_consts.svh
`ifndef FE_CONSTS_SVH
`define FE_CONSTS_SVH

`define FE_RESET_PC     64'h0000_0000_8000_0000
// response buffer depth, also the number of fetch credits
`define FE_RSP_DEPTH    4
`define FE_DEC_CREDITS  4
`define FE_NOP_INST     32'h0000_0013

`endif

//--- rtl/fe_ctrl_pkg.sv
`default_nettype none

// front end control types
package fe_ctrl_pkg;

    // stall vector, bit 0 holds the fetch side, bit 1 holds if/id
    typedef logic [1:0] stall_vec_t;

    localparam int HOLD_IF = 0;
    localparam int HOLD_ID = 1;

    // wide enough for a depth of up to 7 entries
    typedef logic [2:0] credit_t;

endpackage

`default_nettype wire

//--- rtl/fe_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "fe_consts.svh"

module fe_decode (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  flush,
    input  logic                  id_valid,
    input  rv_isa_pkg::pc_t       id_pc,
    input  rv_isa_pkg::inst_t     id_inst,
    input  logic                  dec_credit,
    output logic                  dec_stall,
    output logic                  dec_valid,
    output rv_isa_pkg::pc_t       dec_pc,
    output rv_isa_pkg::inst_t     dec_inst,
    output rv_isa_pkg::op_class_e dec_op_class,
    output rv_isa_pkg::reg_idx_t  dec_rd,
    output rv_isa_pkg::reg_idx_t  dec_rs1,
    output rv_isa_pkg::reg_idx_t  dec_rs2,
    output rv_isa_pkg::imm_t      dec_imm
);

    import rv_isa_pkg::*;
    import fe_ctrl_pkg::*;

    credit_t   credits;
    logic      fire;
    op_class_e op_class;
    imm_t      imm;
    imm_t      imm_i;
    imm_t      imm_s;
    imm_t      imm_b;
    imm_t      imm_u;
    imm_t      imm_j;

    // immediate formats, bit 31 is always the sign
    assign imm_i = {{52{id_inst[31]}}, id_inst[31:20]};
    assign imm_s = {{52{id_inst[31]}}, id_inst[31:25], id_inst[11:7]};
    assign imm_b = {{51{id_inst[31]}}, id_inst[31], id_inst[7], id_inst[30:25],
                    id_inst[11:8], 1'b0};
    assign imm_u = {{32{id_inst[31]}}, id_inst[31:12], 12'h000};
    assign imm_j = {{43{id_inst[31]}}, id_inst[31], id_inst[19:12], id_inst[20],
                    id_inst[30:21], 1'b0};

    always_comb begin
        imm = '0;
        case (id_inst[6:0])
            7'b0010011: begin op_class = alu_imm;   imm = imm_i; end
            7'b0110011: begin op_class = alu_reg;                end
            7'b0011011: begin op_class = alu_imm_w; imm = imm_i; end
            7'b0111011: begin op_class = alu_reg_w;              end
            7'b0000011: begin op_class = load;      imm = imm_i; end
            7'b0100011: begin op_class = store;     imm = imm_s; end
            7'b1100011: begin op_class = branch;    imm = imm_b; end
            7'b1101111: begin op_class = jal;       imm = imm_j; end
            7'b1100111: begin op_class = jalr;      imm = imm_i; end
            7'b0110111: begin op_class = lui;       imm = imm_u; end
            7'b0010111: begin op_class = auipc;     imm = imm_u; end
            7'b1110011: begin op_class = system;    imm = imm_i; end
            default:    begin op_class = illegal;                end
        endcase
    end

    // an entry leaves only with a credit in hand
    assign dec_stall = id_valid && (credits == '0);
    assign fire      = id_valid && (credits != '0) && !flush;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credits   <= credit_t'(`FE_DEC_CREDITS);
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= fire;
            if (fire && !dec_credit) begin
                credits <= credits - credit_t'(1);
            end else if (dec_credit && !fire) begin
                credits <= credits + credit_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            dec_pc       <= id_pc;
            dec_inst     <= id_inst;
            dec_op_class <= op_class;
            dec_rd       <= id_inst[11:7];
            dec_rs1      <= id_inst[19:15];
            dec_rs2      <= id_inst[24:20];
            dec_imm      <= imm;
        end
    end

endmodule

`default_nettype wire

//--- rtl/fe_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module fe_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     flush,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     not_empty
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    payload_t      mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          do_pop;

    // wraps at DEPTH, so non power of two depths work
    function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
        return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign not_empty = (count != '0);
    assign do_pop    = pop && not_empty;
    assign pop_data  = mem[rd_ptr];     // head visible the cycle after its push

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= ptr_inc(wr_ptr);
            if (do_pop) rd_ptr <= ptr_inc(rd_ptr);
            count <= count + CW'(push) - CW'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push && !flush) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

`default_nettype wire

//--- rtl/fe_hazard_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "fe_consts.svh"

module fe_hazard_ctrl (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    imem_req_valid,
    input  logic                    imem_rsp_valid,
    input  logic                    redirect_valid,
    input  logic                    id_pop,
    input  logic                    dec_stall,
    output logic                    fetch_allow,
    output logic                    rsp_accept,
    output logic                    flush,
    output fe_ctrl_pkg::stall_vec_t stall_vec
);

    import fe_ctrl_pkg::*;

    credit_t credits;       // free slots in the response path
    credit_t in_flight;     // requests not answered yet, old path included
    credit_t drop_cnt;      // stale answers still to come
    credit_t live_flight;
    logic    drop;

    // outstanding count once this cycle's answer is taken out
    assign live_flight = in_flight - credit_t'(imem_rsp_valid);

    assign drop        = imem_rsp_valid && (drop_cnt != '0);
    assign rsp_accept  = imem_rsp_valid && (drop_cnt == '0) && !redirect_valid;
    assign fetch_allow = (credits != '0) && !redirect_valid;
    assign flush       = redirect_valid;

    assign stall_vec[HOLD_ID] = dec_stall;
    assign stall_vec[HOLD_IF] = dec_stall | redirect_valid;  // no handoff on a redirect edge

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credits   <= credit_t'(`FE_RSP_DEPTH);
            in_flight <= '0;
            drop_cnt  <= '0;
        end else begin
            in_flight <= live_flight + credit_t'(imem_req_valid);
            if (redirect_valid) begin
                // buffers are flushed, only the answers in flight stay owed
                drop_cnt <= live_flight;
                credits  <= credit_t'(`FE_RSP_DEPTH) - live_flight;
            end else begin
                drop_cnt <= drop_cnt - credit_t'(drop);
                credits  <= credits + credit_t'(id_pop) + credit_t'(drop)
                            - credit_t'(imem_req_valid);
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/fe_if_id_reg.sv
`timescale 1ns/1ps
`default_nettype none

`include "fe_consts.svh"

module fe_if_id_reg (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    flush,
    input  fe_ctrl_pkg::stall_vec_t stall_vec,
    input  rv_isa_pkg::pc_t         pc_head,
    input  rv_isa_pkg::inst_t       inst_head,
    input  logic                    heads_valid,
    output logic                    id_pop,
    output logic                    id_valid,
    output rv_isa_pkg::pc_t         id_pc,
    output rv_isa_pkg::inst_t       id_inst
);

    import fe_ctrl_pkg::*;

    logic hold_if;
    logic hold_id;

    assign hold_if = stall_vec[HOLD_IF];
    assign hold_id = stall_vec[HOLD_ID];

    // take the fifo heads whenever the fetch side is not held
    assign id_pop = heads_valid && !hold_if;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id_valid <= 1'b0;
            id_pc    <= '0;
            id_inst  <= `FE_NOP_INST;
        end else if (flush) begin
            id_valid <= 1'b0;
            id_pc    <= '0;
            id_inst  <= `FE_NOP_INST;
        end else if (hold_id) begin
            id_valid <= id_valid;   // keep entry until decode has a credit
        end else if (id_pop) begin
            id_valid <= 1'b1;
            id_pc    <= pc_head;
            id_inst  <= inst_head;
        end else begin
            id_valid <= 1'b0;       // bubble
            id_pc    <= '0;
            id_inst  <= `FE_NOP_INST;
        end
    end

endmodule

`default_nettype wire

//--- rtl/fe_pc_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "fe_consts.svh"

module fe_pc_gen (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            redirect_valid,
    input  rv_isa_pkg::pc_t redirect_pc,
    input  logic            fetch_allow,
    output logic            imem_req_valid,
    output rv_isa_pkg::pc_t imem_req_addr
);

    import rv_isa_pkg::*;

    pc_t  pc;
    logic running;  // first request goes out one cycle after reset lifts

    assign imem_req_valid = running && fetch_allow && !redirect_valid;
    assign imem_req_addr  = pc;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            running <= 1'b0;
        end else begin
            running <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= `FE_RESET_PC;
        end else if (redirect_valid) begin
            pc <= redirect_pc;          // nothing issued this cycle
        end else if (imem_req_valid) begin
            pc <= pc + 64'd4;           // sequential, no prediction
        end
    end

endmodule

`default_nettype wire

//--- rtl/fe_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "fe_consts.svh"

module fe_top (
    input  logic                  clk,
    input  logic                  arst_n,
    // instruction memory
    output logic                  imem_req_valid,
    output rv_isa_pkg::pc_t       imem_req_addr,
    input  logic                  imem_rsp_valid,
    input  rv_isa_pkg::inst_t     imem_rsp_inst,
    // from execute
    input  logic                  redirect_valid,
    input  rv_isa_pkg::pc_t       redirect_pc,
    // to the consumer
    output logic                  dec_valid,
    output rv_isa_pkg::pc_t       dec_pc,
    output rv_isa_pkg::inst_t     dec_inst,
    output rv_isa_pkg::op_class_e dec_op_class,
    output rv_isa_pkg::reg_idx_t  dec_rd,
    output rv_isa_pkg::reg_idx_t  dec_rs1,
    output rv_isa_pkg::reg_idx_t  dec_rs2,
    output rv_isa_pkg::imm_t      dec_imm,
    input  logic                  dec_credit
);

    import rv_isa_pkg::*;
    import fe_ctrl_pkg::*;

    logic       fetch_allow;
    logic       rsp_accept;
    logic       flush;
    logic       dec_stall;
    logic       id_pop;
    logic       id_valid;
    logic       rsp_not_empty;
    stall_vec_t stall_vec;
    pc_t        pc_head;
    pc_t        id_pc;
    inst_t      inst_head;
    inst_t      id_inst;

    fe_pc_gen u_pc_gen (
        .clk            (clk),
        .arst_n         (arst_n),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .fetch_allow    (fetch_allow),
        .imem_req_valid (imem_req_valid),
        .imem_req_addr  (imem_req_addr)
    );

    fe_hazard_ctrl u_hazard_ctrl (
        .clk            (clk),
        .arst_n         (arst_n),
        .imem_req_valid (imem_req_valid),
        .imem_rsp_valid (imem_rsp_valid),
        .redirect_valid (redirect_valid),
        .id_pop         (id_pop),
        .dec_stall      (dec_stall),
        .fetch_allow    (fetch_allow),
        .rsp_accept     (rsp_accept),
        .flush          (flush),
        .stall_vec      (stall_vec)
    );

    // address of every request still owed an answer or waiting in the buffer
    fe_fifo #(.payload_t(pc_t), .DEPTH(`FE_RSP_DEPTH)) u_pc_fifo (
        .clk       (clk),
        .arst_n    (arst_n),
        .flush     (flush),
        .push      (imem_req_valid),
        .push_data (imem_req_addr),
        .pop       (id_pop),
        .pop_data  (pc_head),
        .not_empty ()   // a buffered response always has its pc ahead of it
    );

    fe_fifo #(.payload_t(inst_t), .DEPTH(`FE_RSP_DEPTH)) u_rsp_fifo (
        .clk       (clk),
        .arst_n    (arst_n),
        .flush     (flush),
        .push      (rsp_accept),
        .push_data (imem_rsp_inst),
        .pop       (id_pop),
        .pop_data  (inst_head),
        .not_empty (rsp_not_empty)
    );

    fe_if_id_reg u_if_id_reg (
        .clk         (clk),
        .arst_n      (arst_n),
        .flush       (flush),
        .stall_vec   (stall_vec),
        .pc_head     (pc_head),
        .inst_head   (inst_head),
        .heads_valid (rsp_not_empty),
        .id_pop      (id_pop),
        .id_valid    (id_valid),
        .id_pc       (id_pc),
        .id_inst     (id_inst)
    );

    fe_decode u_decode (
        .clk          (clk),
        .arst_n       (arst_n),
        .flush        (flush),
        .id_valid     (id_valid),
        .id_pc        (id_pc),
        .id_inst      (id_inst),
        .dec_credit   (dec_credit),
        .dec_stall    (dec_stall),
        .dec_valid    (dec_valid),
        .dec_pc       (dec_pc),
        .dec_inst     (dec_inst),
        .dec_op_class (dec_op_class),
        .dec_rd       (dec_rd),
        .dec_rs1      (dec_rs1),
        .dec_rs2      (dec_rs2),
        .dec_imm      (dec_imm)
    );

endmodule

`default_nettype wire

//--- rtl/rv_isa_pkg.sv
`default_nettype none

// RV64I encoding types used by fetch and decode
package rv_isa_pkg;

    typedef logic [63:0] pc_t;      // byte address
    typedef logic [31:0] inst_t;    // raw 32-bit word, no compressed forms
    typedef logic [4:0]  reg_idx_t;
    typedef logic [63:0] imm_t;     // already sign extended to xlen

    // one class per major opcode
    typedef enum logic [3:0] {
        alu_imm   = 4'd0,
        alu_reg   = 4'd1,
        alu_imm_w = 4'd2,   // 32-bit ops on rv64
        alu_reg_w = 4'd3,
        load      = 4'd4,
        store     = 4'd5,
        branch    = 4'd6,
        jal       = 4'd7,
        jalr      = 4'd8,
        lui       = 4'd9,
        auipc     = 4'd10,
        system    = 4'd11,
        illegal   = 4'd12
    } op_class_e;

endpackage

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build and run the front end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sources.f --top-module fe_tb -o fe_sim

./obj_dir/fe_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TB FAILED" sim.log; then
    exit 1
fi
if ! grep -q "TB PASSED" sim.log; then
    exit 1
fi
exit 0

//--- sources.f
+incdir+rtl
rtl/rv_isa_pkg.sv
rtl/fe_ctrl_pkg.sv
rtl/fe_fifo.sv
rtl/fe_pc_gen.sv
rtl/fe_hazard_ctrl.sv
rtl/fe_if_id_reg.sv
rtl/fe_decode.sv
rtl/fe_top.sv
tb/fe_tb.sv

//--- tb/fe_golden.txt
# m <addr> <inst> | r <trigger pc> <target pc>
# e <pc> <class> <rd> <rs1> <rs2> <imm>   (class and registers decimal, rest hex)
m 80000000 fff00093
m 80000004 fe21ae23
m 80000008 fe520ce3
m 8000000c fffff337
m 80000010 ff1ff0ef
m 80000014 ffe403e7
m 80000018 80000497
m 8000001c 8005851b
m 80000020 ffffffff
m 80000024 00e68633
m 80000028 00883783
m 8000002c 00000073
m 80000030 00100093
m 80000034 00200113
m 80000038 00300193
m 80000100 403100bb
r 8000002c 80000100
r 80000104 8000001c
e 80000000 0 1 0 31 ffffffffffffffff
e 80000004 5 28 3 2 fffffffffffffffc
e 80000008 6 25 4 5 fffffffffffffff8
e 8000000c 9 6 31 31 fffffffffffff000
e 80000010 7 1 31 17 fffffffffffffff0
e 80000014 8 7 8 30 fffffffffffffffe
e 80000018 10 9 0 0 ffffffff80000000
e 8000001c 2 10 11 0 fffffffffffff800
e 80000020 12 31 31 31 0000000000000000
e 80000024 1 12 13 14 0000000000000000
e 80000028 4 15 16 8 0000000000000008
e 8000002c 11 0 0 0 0000000000000000
e 80000100 3 1 2 3 0000000000000000
e 80000104 0 0 0 0 0000000000000000
e 8000001c 2 10 11 0 fffffffffffff800
e 80000020 12 31 31 31 0000000000000000
e 80000024 1 12 13 14 0000000000000000
e 80000028 4 15 16 8 0000000000000008
e 8000002c 11 0 0 0 0000000000000000

//--- tb/fe_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "fe_consts.svh"

module fe_tb;

    import rv_isa_pkg::*;
    import fe_ctrl_pkg::*;

    logic      clk;
    logic      arst_n;
    logic      imem_req_valid;
    pc_t       imem_req_addr;
    logic      imem_rsp_valid;
    inst_t     imem_rsp_inst;
    logic      redirect_valid;
    pc_t       redirect_pc;
    logic      dec_valid;
    pc_t       dec_pc;
    inst_t     dec_inst;
    op_class_e dec_op_class;
    reg_idx_t  dec_rd;
    reg_idx_t  dec_rs1;
    reg_idx_t  dec_rs2;
    imm_t      dec_imm;
    logic      dec_credit;

    inst_t     mem [pc_t];      // sparse program image
    pc_t       rule_trig [$];
    pc_t       rule_tgt [$];
    pc_t       exp_pc [$];
    op_class_e exp_cls [$];
    reg_idx_t  exp_rd [$];
    reg_idx_t  exp_rs1 [$];
    reg_idx_t  exp_rs2 [$];
    imm_t      exp_imm [$];
    pc_t       pend_addr [$];   // requests the memory still owes
    int        pend_due [$];

    integer seed = 10437;
    int     cyc = 0;
    int     last_due = 0;
    int     rule_idx = 0;
    int     owed = 0;           // credits not yet handed back
    int     req_cnt = 0;
    int     rsp_cnt = 0;
    int     out_cnt = 0;
    int     ret_cnt = 0;
    int     value_errors = 0;
    int     other_errors = 0;
    logic   loaded = 1'b0;
    logic   done = 1'b0;

    fe_top fe_top_i (
        .clk            (clk),
        .arst_n         (arst_n),
        .imem_req_valid (imem_req_valid),
        .imem_req_addr  (imem_req_addr),
        .imem_rsp_valid (imem_rsp_valid),
        .imem_rsp_inst  (imem_rsp_inst),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .dec_valid      (dec_valid),
        .dec_pc         (dec_pc),
        .dec_inst       (dec_inst),
        .dec_op_class   (dec_op_class),
        .dec_rd         (dec_rd),
        .dec_rs1        (dec_rs1),
        .dec_rs2        (dec_rs2),
        .dec_imm        (dec_imm),
        .dec_credit     (dec_credit)
    );

    always #5 clk = ~clk;

    function automatic credit_t clamp_count(input int n);
        return (n > 7) ? credit_t'(7) : credit_t'(n);
    endfunction

    // word the program image holds at an address, nop where nothing was loaded
    function automatic inst_t image_word(input pc_t addr);
        return mem.exists(addr) ? mem[addr] : `FE_NOP_INST;
    endfunction

    task automatic check_dec(input pc_t e_pc, input inst_t e_inst, input op_class_e e_cls,
                             input reg_idx_t e_rd, input reg_idx_t e_rs1,
                             input reg_idx_t e_rs2, input imm_t e_imm);
        if (dec_pc !== e_pc || dec_inst !== e_inst || dec_op_class !== e_cls ||
            dec_rd !== e_rd || dec_rs1 !== e_rs1 || dec_rs2 !== e_rs2 ||
            dec_imm !== e_imm) begin
            value_errors++;
            $display("mismatch at %0t: pc %h inst %h cls %0d rd %0d rs1 %0d rs2 %0d imm %h",
                     $time, dec_pc, dec_inst, dec_op_class, dec_rd, dec_rs1, dec_rs2,
                     dec_imm);
            $display("  expected pc %h inst %h cls %0d rd %0d rs1 %0d rs2 %0d imm %h",
                     e_pc, e_inst, e_cls, e_rd, e_rs1, e_rs2, e_imm);
        end
    endtask

    // count must stay within the credit limit
    task automatic check_credit(input string what, input credit_t count, input credit_t limit);
        if (count > limit) begin
            value_errors++;
            $display("mismatch at %0t: %s is %0d, limit %0d", $time, what, count, limit);
        end
    endtask

    task automatic load_golden();
        int    fd;
        int    n;
        int    bad_lines;
        int    cls;
        int    rd;
        int    rs1;
        int    rs2;
        pc_t   a;
        pc_t   b;
        imm_t  imm;
        string line;
        bad_lines = 0;
        fd = $fopen("tb/fe_golden.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("could not open the golden file tb/fe_golden.txt");
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() == 0) continue;
            if (line[0] == "m") begin
                n = $sscanf(line, "m %h %h", a, b);
                if (n != 2) bad_lines++;
                mem[a] = inst_t'(b);
            end else if (line[0] == "r") begin
                n = $sscanf(line, "r %h %h", a, b);
                if (n != 2) bad_lines++;
                rule_trig.push_back(a);
                rule_tgt.push_back(b);
            end else if (line[0] == "e") begin
                n = $sscanf(line, "e %h %d %d %d %d %h", a, cls, rd, rs1, rs2, imm);
                if (n != 6) bad_lines++;
                exp_pc.push_back(a);
                exp_cls.push_back(op_class_e'(cls));
                exp_rd.push_back(reg_idx_t'(rd));
                exp_rs1.push_back(reg_idx_t'(rs1));
                exp_rs2.push_back(reg_idx_t'(rs2));
                exp_imm.push_back(imm);
            end
        end
        $fclose(fd);
        if (bad_lines != 0) begin
            other_errors++;
            $display("%0d lines of the golden file could not be read", bad_lines);
        end
    endtask

    // requests and counters, read before the edge updates the DUT
    always @(posedge clk) begin
        int lat;
        int due;
        if (!arst_n) begin
            if (imem_req_valid !== 1'b0 || dec_valid !== 1'b0) begin
                other_errors++;
                $display("request or decode valid was high during reset at %0t", $time);
            end
        end else begin
            if (imem_req_valid) begin
                lat = 1 + ($unsigned($random(seed)) % 4);
                due = cyc + lat;
                if (due <= last_due) due = last_due + 1;   // memory answers in order
                pend_addr.push_back(imem_req_addr);
                pend_due.push_back(due);
                last_due = due;
                req_cnt++;
            end
            if (imem_rsp_valid) rsp_cnt++;
            if (dec_valid) out_cnt++;
            if (dec_credit) ret_cnt++;
            check_credit("fetch in flight", clamp_count(req_cnt - rsp_cnt),
                         credit_t'(`FE_RSP_DEPTH));
            check_credit("decode outstanding", clamp_count(out_cnt - ret_cnt),
                         credit_t'(`FE_DEC_CREDITS));
        end
        cyc++;
    end

    always @(negedge clk) begin
        redirect_valid = 1'b0;
        imem_rsp_valid = 1'b0;
        dec_credit     = 1'b0;
        if (arst_n && loaded) begin
            if (dec_valid) begin
                if (exp_pc.size() == 0) begin
                    other_errors++;
                    $display("decode output at pc %h after the expected stream ended", dec_pc);
                end else begin
                    check_dec(exp_pc[0], image_word(exp_pc[0]), exp_cls[0], exp_rd[0],
                              exp_rs1[0], exp_rs2[0], exp_imm[0]);
                    void'(exp_pc.pop_front());
                    void'(exp_cls.pop_front());
                    void'(exp_rd.pop_front());
                    void'(exp_rs1.pop_front());
                    void'(exp_rs2.pop_front());
                    void'(exp_imm.pop_front());
                    if (exp_pc.size() == 0) done = 1'b1;
                end
                owed++;
                if (rule_idx < rule_trig.size() && dec_pc == rule_trig[rule_idx]) begin
                    redirect_valid = 1'b1;  // execute resolves a taken jump
                    redirect_pc    = rule_tgt[rule_idx];
                    rule_idx++;
                end
            end
            if (pend_due.size() > 0 && pend_due[0] <= cyc) begin
                imem_rsp_valid = 1'b1;
                imem_rsp_inst  = image_word(pend_addr[0]);
                void'(pend_addr.pop_front());
                void'(pend_due.pop_front());
            end
            // consumer stalls for half of every 50 cycles
            if (owed > 0 && (cyc % 50) >= 25 && ($random(seed) & 1)) begin
                dec_credit = 1'b1;
                owed--;
            end
        end
    end

    initial begin
        clk            = 1'b0;
        arst_n         = 1'b0;
        imem_rsp_valid = 1'b0;
        imem_rsp_inst  = '0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        dec_credit     = 1'b0;
        load_golden();
        loaded = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        if (exp_pc.size() == 0) done = 1'b1;
        wait (done);
        @(posedge clk);
        #1;     // counters of the last edge settle first
        $display("errors: %0d mismatch, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        int limit;
        wait (loaded);
        limit = exp_pc.size() * 60 + 20;    // plus the reset cycles
        repeat (limit) @(posedge clk);
        $display("timeout, %0d expected outputs never arrived", exp_pc.size());
        $display("errors: %0d mismatch, %0d other", value_errors, other_errors + 1);
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire
